//--- project.f
lcd_pkg.sv
lcd_timer.sv
lcd_sequencer.sv
lcd_bus_driver.sv
lcd_controller.sv
tb_clock.sv
tb_lcd.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f project.f --top-module tb_lcd \
	&& ./obj_dir/Vtb_lcd > sim.log \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb_lcd.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lcd;

	import lcd_pkg::*;

	localparam int U          = 4;  // clocks per microsecond in simulation
	localparam int TIMER_BITS = 12;
	localparam int WRITES     = 20; // random writes after the directed one
	localparam logic [6:0] CFG = 7'b1011010; // 2 lines, display and cursor on, increment
	localparam int INIT_CLKS = (T_POWER_UP_US + 4 * T_INIT_PULSE_US + T_WAIT_FUNC_US
		+ T_WAIT_DISP_US + T_WAIT_CLEAR_US + T_WAIT_ENTRY_US) * U;
	localparam int WINDOW_LIMIT = T_WRITE_WINDOW_US * U + 10;

	logic       clk, reset;
	logic [6:0] config_word;
	logic       lcd_enable;
	logic [9:0] lcd_bus;
	logic       e, rs, rw, busy;
	logic [7:0] lcd_data;

	int         cyc;              // samples since reset release
	logic       e_q, busy_q, init_done;
	int         pulse_cnt, rise_cyc, fall_cyc;
	logic [7:0] rise_data;
	int         win_cnt, win_cyc, win_pulses;
	logic [9:0] exp_word;

	int          assert_errs  = 0;
	int          check_errs   = 0;
	int          timeout_errs = 0;
	logic [16:0] lfsr = 17'd91845;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_tb_clock (.clk(clk), .reset(reset));

	lcd_controller #(
		.CLK_PER_US (U),
		.TIMER_BITS (TIMER_BITS)
	) u_lcd_controller (
		.clk         (clk),
		.reset       (reset),
		.config_word (config_word),
		.lcd_enable  (lcd_enable),
		.lcd_bus     (lcd_bus),
		.e           (e),
		.rs          (rs),
		.rw          (rw),
		.lcd_data    (lcd_data),
		.busy        (busy)
	);

	// command bytes: lines, font / display, cursor, blink / increment, shift
	function automatic logic [7:0] cmd_byte(input int idx, input logic [6:0] c);
		case (idx)
			0:       cmd_byte = {4'b0011, c[6], c[5], 2'b00};
			1:       cmd_byte = {5'b00001, c[4], c[3], c[2]};
			2:       cmd_byte = 8'h01;
			3:       cmd_byte = {6'b000001, c[1], c[0]};
			default: cmd_byte = 8'h00;
		endcase
	endfunction

	function automatic int gap_clks(input int idx); // settle time after command idx
		case (idx)
			1:       gap_clks = T_WAIT_FUNC_US * U;
			2:       gap_clks = T_WAIT_DISP_US * U;
			default: gap_clks = T_WAIT_CLEAR_US * U;
		endcase
	endfunction

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		lfsr_step = {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic draw(input int n, output logic [9:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[8:0], lfsr[0]};
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			cyc       <= 0;
			e_q       <= 1'b0;
			busy_q    <= 1'b1;
			init_done <= 1'b0;
			pulse_cnt <= 0;
			win_cnt   <= 0;
		end else begin
			cyc    <= cyc + 1;
			e_q    <= e;
			busy_q <= busy;
			if (e && !e_q) begin
				rise_cyc  <= cyc;
				rise_data <= lcd_data;
				pulse_cnt <= pulse_cnt + 1;
			end
			if (!e && e_q)
				fall_cyc <= cyc;
			if (!busy && busy_q)
				init_done <= 1'b1;
			if (busy && !busy_q && init_done) begin // write window opens
				win_cnt    <= win_cnt + 1;
				win_cyc    <= cyc;
				win_pulses <= pulse_cnt;
			end
			if (lcd_enable && !busy)
				exp_word <= lcd_bus;
		end
	end

	task automatic flag_error(input string msg);
		assert_errs++;
		$display("FAILED at %0d ns: %s", $time, msg);
	endtask

	assert property (@(posedge clk) disable iff (reset)
		cyc == 0 |-> busy && !e && !rs && !rw && lcd_data == 8'h00)
		else flag_error("outputs not at reset values");
	assert property (@(posedge clk) disable iff (reset) cyc <= INIT_CLKS |-> busy)
		else flag_error("busy low during power-up or init");
	assert property (@(posedge clk) disable iff (reset)
		$rose(e) && pulse_cnt == 0 |-> cyc == T_POWER_UP_US * U + 1) // seen one edge late
		else flag_error("first init pulse at wrong time");
	assert property (@(posedge clk) disable iff (reset)
		$rose(e) && !init_done |-> pulse_cnt < 4 && lcd_data == cmd_byte(pulse_cnt, CFG))
		else flag_error("wrong init command byte or extra init pulse");
	assert property (@(posedge clk) disable iff (reset)
		$rose(e) && !init_done && pulse_cnt > 0 |-> cyc - fall_cyc == gap_clks(pulse_cnt))
		else flag_error("wrong settle gap between init pulses");
	assert property (@(posedge clk) disable iff (reset)
		$fell(e) && !init_done |-> cyc - rise_cyc == T_INIT_PULSE_US * U)
		else flag_error("wrong init pulse width");
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy) && !init_done |-> pulse_cnt == 4 && cyc == INIT_CLKS + 1
		&& cyc - fall_cyc == T_WAIT_ENTRY_US * U)
		else flag_error("init did not end after the entry mode wait");
	assert property (@(posedge clk) disable iff (reset)
		$past(lcd_enable && !busy) |-> busy && {rs, rw, lcd_data} == $past(lcd_bus))
		else flag_error("bus word not presented after accept");
	assert property (@(posedge clk) disable iff (reset)
		$rose(e) && init_done |-> cyc - win_cyc == T_WRITE_SETUP_US * U
		&& {rs, rw, lcd_data} == exp_word)
		else flag_error("write pulse rises at wrong time or with wrong word");
	assert property (@(posedge clk) disable iff (reset)
		$fell(e) && init_done |-> cyc - rise_cyc == T_WRITE_HIGH_US * U && lcd_data == rise_data)
		else flag_error("wrong write pulse width");
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy) && init_done |-> cyc - win_cyc == T_WRITE_WINDOW_US * U
		&& pulse_cnt == win_pulses + 1)
		else flag_error("write window length or pulse count wrong");
	assert property (@(posedge clk) disable iff (reset)
		busy && $past(busy) && init_done |-> $stable({rs, rw, lcd_data}))
		else flag_error("pins changed inside the write window");
	assert property (@(posedge clk) disable iff (reset)
		!busy && init_done |-> !e && !rs && !rw && lcd_data == 8'h00)
		else flag_error("outputs not zero while idle");

	task automatic finish_run();
		$display("errors: %0d assertion, %0d check, %0d timeout",
			assert_errs, check_errs, timeout_errs);
		if (assert_errs + check_errs + timeout_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// returns on the rising edge after busy is seen at level
	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (busy !== level) begin
			if (n >= limit) begin
				timeout_errs++;
				$display("timed out after %0d cycles %s", n, what);
				finish_run();
			end
			@(negedge clk);
			n++;
		end
		@(posedge clk);
	endtask

	task automatic strobe(input logic [9:0] word);
		lcd_enable <= 1'b1;
		lcd_bus    <= word;
		@(posedge clk);
		lcd_enable <= 1'b0;
	endtask

	task automatic write_word(input logic [9:0] word, input int gap, input int extra);
		int i;
		wait_busy(1'b0, WINDOW_LIMIT, "waiting for the write window to close");
		repeat (gap) @(posedge clk);
		strobe(word);
		for (i = 0; i < extra; i++) begin // these land while busy is high
			repeat (3) @(posedge clk);
			strobe(word ^ 10'h3FF);
		end
	endtask

	initial begin
		int         i;
		int         gap;
		logic [9:0] bits;
		logic [9:0] word;
		config_word = CFG;
		lcd_enable  = 1'b0;
		lcd_bus     = '0;
		wait_busy(1'b0, INIT_CLKS + 100, "waiting for init to finish");
		write_word(10'h2A5, 0, 3);
		for (i = 0; i < WRITES; i++) begin
			draw(10, bits);
			word = bits;
			draw(3, bits);
			gap = int'(bits);
			draw(1, bits);
			write_word(word, gap, int'(bits));
		end
		wait_busy(1'b0, WINDOW_LIMIT, "waiting for the last write");
		repeat (4) @(posedge clk);
		if (win_cnt != WRITES + 1) begin
			check_errs++;
			$display("FAILED at %0d ns: %0d write windows, expected %0d",
				$time, win_cnt, WRITES + 1);
		end
		if (pulse_cnt != WRITES + 5) begin
			check_errs++;
			$display("FAILED at %0d ns: %0d e pulses, expected %0d",
				$time, pulse_cnt, WRITES + 5);
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	always begin
		clk = 1'b0;
		#(PERIOD_NS / 2);
		clk = 1'b1;
		#(PERIOD_NS / 2);
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // released on a rising edge like any other input
	end

endmodule

`default_nettype wire

//--- lcd_controller.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_controller #(
	parameter int CLK_PER_US = 360,
	parameter int TIMER_BITS = 18 // must hold 500 * CLK_PER_US
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [6:0] config_word,
	input  logic       lcd_enable,
	input  logic [9:0] lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	import lcd_pkg::*;

	logic                  timer_load;
	logic [TIMER_BITS-1:0] timer_value;
	logic                  timer_done;
	lcd_op_t               op;
	logic                  e_level;
	logic                  busy_level;
	logic                  cfg_capture;
	logic                  bus_capture;

	lcd_sequencer #(
		.CLK_PER_US (CLK_PER_US),
		.TIMER_BITS (TIMER_BITS)
	) u_lcd_sequencer (
		.clk         (clk),
		.reset       (reset),
		.lcd_enable  (lcd_enable),
		.timer_done  (timer_done),
		.timer_load  (timer_load),
		.timer_value (timer_value),
		.op          (op),
		.e_level     (e_level),
		.busy_level  (busy_level),
		.cfg_capture (cfg_capture),
		.bus_capture (bus_capture)
	);

	lcd_timer #(
		.TIMER_BITS (TIMER_BITS)
	) u_lcd_timer (
		.clk   (clk),
		.reset (reset),
		.load  (timer_load),
		.value (timer_value),
		.done  (timer_done)
	);

	lcd_bus_driver u_lcd_bus_driver (
		.clk         (clk),
		.reset       (reset),
		.op          (op),
		.e_level     (e_level),
		.busy_level  (busy_level),
		.cfg_capture (cfg_capture),
		.bus_capture (bus_capture),
		.config_word (config_word),
		.lcd_bus     (lcd_bus),
		.e           (e),
		.rs          (rs),
		.rw          (rw),
		.lcd_data    (lcd_data),
		.busy        (busy)
	);

endmodule

`default_nettype wire

//--- lcd_bus_driver.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_driver (
	input  logic             clk,
	input  logic             reset,
	input  lcd_pkg::lcd_op_t op,
	input  logic             e_level,
	input  logic             busy_level,
	input  logic             cfg_capture,
	input  logic             bus_capture,
	input  logic [6:0]       config_word,
	input  logic [9:0]       lcd_bus,
	output logic             e,
	output logic             rs,
	output logic             rw,
	output logic [7:0]       lcd_data,
	output logic             busy
);

	import lcd_pkg::*;

	// config_word: lines, font, display on, cursor, blink, increment, shift
	logic [6:0] cfg;
	logic [9:0] bus_word; // rs, rw, data
	logic [7:0] cmd_byte;

	always_ff @(posedge clk) begin
		if (cfg_capture) begin
			cfg <= config_word;
		end
		if (bus_capture) begin
			bus_word <= lcd_bus;
		end
	end

	always_comb begin
		case (op)
			OP_FUNCTION_SET: cmd_byte = {4'b0011, cfg[6], cfg[5], 2'b00};
			OP_DISPLAY_CTRL: cmd_byte = {5'b00001, cfg[4], cfg[3], cfg[2]};
			OP_CLEAR:        cmd_byte = 8'b0000_0001;
			OP_ENTRY_MODE:   cmd_byte = {6'b000001, cfg[1], cfg[0]};
			default:         cmd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
			busy     <= 1'b1;
		end else if (bus_capture) begin // present the word on the accept edge
			e        <= 1'b0;
			rs       <= lcd_bus[9];
			rw       <= lcd_bus[8];
			lcd_data <= lcd_bus[7:0];
			busy     <= 1'b1;
		end else begin
			busy <= busy_level;
			case (op)
				OP_WRITE: begin // held for the whole window
					e        <= e_level;
					rs       <= bus_word[9];
					rw       <= bus_word[8];
					lcd_data <= bus_word[7:0];
				end
				OP_NONE: begin
					e        <= 1'b0;
					rs       <= 1'b0;
					rw       <= 1'b0;
					lcd_data <= 8'h00;
				end
				default: begin // init commands are instruction writes
					e        <= e_level;
					rs       <= 1'b0;
					rw       <= 1'b0;
					lcd_data <= e_level ? cmd_byte : 8'h00;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lcd_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_sequencer #(
	parameter int CLK_PER_US = 360,
	parameter int TIMER_BITS = 18
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  lcd_enable,
	input  logic                  timer_done,
	output logic                  timer_load,
	output logic [TIMER_BITS-1:0] timer_value,
	output lcd_pkg::lcd_op_t      op,
	output logic                  e_level,
	output logic                  busy_level,
	output logic                  cfg_capture,
	output logic                  bus_capture
);

	import lcd_pkg::*;

	// phase lengths in clocks
	// the bus driver adds one register stage, so the phases that start from
	// an external reference are one clock short
	localparam logic [TIMER_BITS-1:0] TK_POWER_UP =
		TIMER_BITS'(T_POWER_UP_US * CLK_PER_US - 1);
	localparam logic [TIMER_BITS-1:0] TK_INIT_PULSE =
		TIMER_BITS'(T_INIT_PULSE_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WAIT_FUNC = TIMER_BITS'(T_WAIT_FUNC_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WAIT_DISP = TIMER_BITS'(T_WAIT_DISP_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WAIT_CLEAR =
		TIMER_BITS'(T_WAIT_CLEAR_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WAIT_ENTRY =
		TIMER_BITS'(T_WAIT_ENTRY_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WR_SETUP =
		TIMER_BITS'(T_WRITE_SETUP_US * CLK_PER_US - 1);
	localparam logic [TIMER_BITS-1:0] TK_WR_HIGH = TIMER_BITS'(T_WRITE_HIGH_US * CLK_PER_US);
	localparam logic [TIMER_BITS-1:0] TK_WR_REST =
		TIMER_BITS'((T_WRITE_WINDOW_US - T_WRITE_SETUP_US - T_WRITE_HIGH_US) * CLK_PER_US);

	lcd_state_t state, state_n;
	lcd_op_t    op_n;
	logic       e_n, busy_n;
	logic [1:0] wr_phase, wr_phase_n; // setup, high, rest
	logic       start;                // first cycle out of reset
	logic       ready;                // idle and busy pin already low

	function automatic logic [TIMER_BITS-1:0] wait_ticks(input lcd_op_t cmd);
		case (cmd)
			OP_FUNCTION_SET: wait_ticks = TK_WAIT_FUNC;
			OP_DISPLAY_CTRL: wait_ticks = TK_WAIT_DISP;
			OP_CLEAR:        wait_ticks = TK_WAIT_CLEAR;
			default:         wait_ticks = TK_WAIT_ENTRY;
		endcase
	endfunction

	function automatic lcd_op_t next_cmd(input lcd_op_t cmd);
		case (cmd)
			OP_FUNCTION_SET: next_cmd = OP_DISPLAY_CTRL;
			OP_DISPLAY_CTRL: next_cmd = OP_CLEAR;
			default:         next_cmd = OP_ENTRY_MODE;
		endcase
	endfunction

	always_comb begin
		state_n     = state;
		op_n        = op;
		e_n         = e_level;
		busy_n      = busy_level;
		wr_phase_n  = wr_phase;
		timer_load  = 1'b0;
		timer_value = '0;
		cfg_capture = 1'b0;
		bus_capture = 1'b0;
		case (state)
			ST_POWER_UP: begin
				if (start) begin
					timer_load  = 1'b1;
					timer_value = TK_POWER_UP;
				end else if (timer_done) begin
					cfg_capture = 1'b1; // panel is up, take the config
					state_n     = ST_INIT_PULSE;
					op_n        = OP_FUNCTION_SET;
					e_n         = 1'b1;
					timer_load  = 1'b1;
					timer_value = TK_INIT_PULSE;
				end
			end
			ST_INIT_PULSE: begin
				if (timer_done) begin
					state_n     = ST_INIT_WAIT;
					e_n         = 1'b0;
					timer_load  = 1'b1;
					timer_value = wait_ticks(op);
				end
			end
			ST_INIT_WAIT: begin
				if (timer_done) begin
					if (op == OP_ENTRY_MODE) begin // last command settled
						state_n = ST_IDLE;
						op_n    = OP_NONE;
						busy_n  = 1'b0;
					end else begin
						state_n     = ST_INIT_PULSE;
						op_n        = next_cmd(op);
						e_n         = 1'b1;
						timer_load  = 1'b1;
						timer_value = TK_INIT_PULSE;
					end
				end
			end
			ST_IDLE: begin
				if (ready && lcd_enable) begin
					bus_capture = 1'b1;
					state_n     = ST_WRITE;
					op_n        = OP_WRITE;
					busy_n      = 1'b1;
					e_n         = 1'b0;
					wr_phase_n  = 2'd0;
					timer_load  = 1'b1;
					timer_value = TK_WR_SETUP;
				end
			end
			ST_WRITE: begin
				if (timer_done) begin
					case (wr_phase)
						2'd0: begin // setup over, raise e
							e_n         = 1'b1;
							wr_phase_n  = 2'd1;
							timer_load  = 1'b1;
							timer_value = TK_WR_HIGH;
						end
						2'd1: begin
							e_n         = 1'b0;
							wr_phase_n  = 2'd2;
							timer_load  = 1'b1;
							timer_value = TK_WR_REST;
						end
						default: begin // window closed
							state_n = ST_IDLE;
							op_n    = OP_NONE;
							busy_n  = 1'b0;
						end
					endcase
				end
			end
			default: begin
				state_n = ST_IDLE;
				op_n    = OP_NONE;
				e_n     = 1'b0;
				busy_n  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_POWER_UP;
			op         <= OP_NONE;
			e_level    <= 1'b0;
			busy_level <= 1'b1;
			wr_phase   <= 2'd0;
			start      <= 1'b1;
			ready      <= 1'b0;
		end else begin
			state      <= state_n;
			op         <= op_n;
			e_level    <= e_n;
			busy_level <= busy_n;
			wr_phase   <= wr_phase_n;
			start      <= 1'b0;
			ready      <= (state == ST_IDLE) && (state_n == ST_IDLE); // tracks busy pin
		end
	end

endmodule

`default_nettype wire

//--- lcd_timer.sv
`timescale 1ns/100ps
`default_nettype none

// Down-counter for the sequencer phases.
// A load of N raises done in the cycle that ends N clocks after the load edge,
// so the sequencer sees it on exactly that edge. N must be at least 1.
module lcd_timer #(
	parameter int TIMER_BITS = 18
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load,
	input  logic [TIMER_BITS-1:0] value,
	output logic                  done
);

	logic [TIMER_BITS-1:0] count;
	logic                  active;

	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			active <= 1'b0;
		end else if (load) begin // reload restarts the count
			count  <= value;
			active <= (value != '0);
		end else if (active) begin
			count <= count - 1'b1;
			if (count == TIMER_BITS'(1)) begin
				active <= 1'b0; // expired this cycle
			end
		end
	end

	assign done = active && (count == TIMER_BITS'(1)); // one-cycle pulse

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// sequencer phases
	typedef enum logic [2:0] {
		ST_POWER_UP,
		ST_INIT_PULSE,
		ST_INIT_WAIT,
		ST_IDLE,
		ST_WRITE
	} lcd_state_t;

	// what the bus driver puts on the pins
	typedef enum logic [2:0] {
		OP_NONE,
		OP_FUNCTION_SET,
		OP_DISPLAY_CTRL,
		OP_CLEAR,
		OP_ENTRY_MODE,
		OP_WRITE
	} lcd_op_t;

	// panel timing in microseconds
	localparam int T_POWER_UP_US     = 500;
	localparam int T_INIT_PULSE_US   = 10;  // e high per init command
	localparam int T_WAIT_FUNC_US    = 50;
	localparam int T_WAIT_DISP_US    = 50;
	localparam int T_WAIT_CLEAR_US   = 200; // clear is the slow one
	localparam int T_WAIT_ENTRY_US   = 100;

	// write window, all measured from the edge where data appears
	localparam int T_WRITE_SETUP_US  = 1;
	localparam int T_WRITE_HIGH_US   = 13;
	localparam int T_WRITE_WINDOW_US = 50;

endpackage

`default_nettype wire
